//--- files.f
+incdir+src
src/wb_pkg.sv
src/trap_if.sv
src/trap_unit.sv
src/csr_bank.sv
src/writeback_stage.sv
src/wb_top.sv
testbench/tb_wb_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_wb_top -f files.f
./obj_dir/Vtb_wb_top > sim.log
cat sim.log
if grep -qx "Finished with no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- testbench/tb_wb_top.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module tb_wb_top;

    import wb_pkg::*;

    // One predicted set of stage outputs
    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [63:0] data;
        logic        redir;
        logic [63:0] target;
        logic        trap;
        logic [63:0] cause;
    } expect_t;

    logic        CLK;
    logic        rst;
    logic        wb_valid;
    logic [63:0] wb_pc;
    logic [63:0] wb_npc;
    logic [31:0] wb_ir;
    logic [63:0] wb_alu_result;
    logic [63:0] wb_mem_result;
    logic [63:0] wb_csr_rdata;
    logic [63:0] wb_csr_wdata;
    exc_flags_t  wb_exc;
    logic        timer_irq;
    logic        ext_irq;
    logic [1:0]  privilege;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [7:0]  PADDR;
    logic [63:0] PWDATA;
    logic        rf_we;
    logic [4:0]  rf_rd;
    logic [63:0] rf_data;
    logic        redirect;
    logic [63:0] redirect_target;
    logic        trap_taken;
    logic [63:0] trap_cause;
    logic [63:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;

    // Model copy of the CSRs and of the interrupt synchronizers
    logic        m_mie;
    logic        m_mpie;
    logic        m_mtie;
    logic        m_meie;
    logic [63:0] m_mtvec;
    logic [63:0] m_mscratch;
    logic [63:0] m_mepc;
    logic [63:0] m_mcause;
    logic [1:0]  m_sync_t;
    logic [1:0]  m_sync_e;

    logic [31:0] seed;
    int          errors;
    int          checks;
    int          test_errs;
    int          irq_taken;
    expect_t     cur_exp;
    expect_t     nxt_exp;

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    wb_top UUT (.*);

    //////////////////////////////
    // Random numbers and model
    //////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    function logic [63:0] rand64();
        return {next_rand(), next_rand()};
    endfunction

    // Maps an APB word offset to its CSR address or to zero
    function automatic logic [11:0] offset_to_csr(input logic [7:0] off);
        case (off)
            `APB_MSTATUS:  return `CSR_MSTATUS;
            `APB_MIE:      return `CSR_MIE;
            `APB_MTVEC:    return `CSR_MTVEC;
            `APB_MSCRATCH: return `CSR_MSCRATCH;
            `APB_MEPC:     return `CSR_MEPC;
            `APB_MCAUSE:   return `CSR_MCAUSE;
            default:       return 12'h000;
        endcase
    endfunction

    function automatic logic [63:0] model_read(input logic [11:0] a);
        logic [63:0] v;
        v = '0;
        case (a)
            `CSR_MSTATUS: begin
                v[`MSTATUS_MIE]  = m_mie;
                v[`MSTATUS_MPIE] = m_mpie;
            end
            `CSR_MIE: begin
                v[`MIE_MTIE] = m_mtie;
                v[`MIE_MEIE] = m_meie;
            end
            `CSR_MTVEC:    v = m_mtvec;
            `CSR_MSCRATCH: v = m_mscratch;
            `CSR_MEPC:     v = m_mepc;
            `CSR_MCAUSE:   v = m_mcause;
            default:       v = '0;
        endcase
        return v;
    endfunction

    task automatic model_write(input logic [11:0] a, input logic [63:0] d);
        case (a)
            `CSR_MSTATUS: begin
                m_mie  = d[`MSTATUS_MIE];
                m_mpie = d[`MSTATUS_MPIE];
            end
            `CSR_MIE: begin
                m_mtie = d[`MIE_MTIE];
                m_meie = d[`MIE_MEIE];
            end
            `CSR_MTVEC:    m_mtvec = d;
            `CSR_MSCRATCH: m_mscratch = d;
            `CSR_MEPC:     m_mepc = d;
            `CSR_MCAUSE:   m_mcause = d;
            default:       ;
        endcase
    endtask

    // Interrupts rank above iaf iam ii ecall lam laf sam saf
    function automatic logic [63:0] rank_cause(input logic [7:0] exc, input logic [1:0] priv,
                                               input logic ext_p, input logic tim_p);
        logic [5:0] ec;
        ec = (priv == 2'd0) ? 6'd8 : ((priv == 2'd1) ? 6'd9 : 6'd11);
        if (ext_p) return {1'b1, 57'd0, 6'd11};
        if (tim_p) return {1'b1, 57'd0, 6'd7};
        // Flag bits msb first are iam iaf ii ecall lam laf sam saf
        if (exc[6]) return 64'd1;
        if (exc[7]) return 64'd0;
        if (exc[5]) return 64'd2;
        if (exc[4]) return {58'd0, ec};
        if (exc[3]) return 64'd4;
        if (exc[2]) return 64'd5;
        if (exc[1]) return 64'd6;
        return 64'd7;
    endfunction

    //////////////////////////////
    // Drive and check
    //////////////////////////////

    // Synchronizer model samples the levels held before this edge
    task automatic tick();
        @(posedge CLK);
        m_sync_t = {m_sync_t[0], timer_irq};
        m_sync_e = {m_sync_e[0], ext_irq};
    endtask

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("** Error %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    // Mode 0 legal, 1 exceptions, 2 irq enabled, 3 irq disabled, 4 CSR only, 5 ecall
    task automatic present(input int mode);
        logic [31:0] r;
        logic [31:0] r2;
        logic [6:0]  op;
        logic [4:0]  rd;
        logic [11:0] csr;
        logic [7:0]  exc;
        logic [1:0]  priv;
        logic [63:0] pc;
        logic [63:0] npc;
        logic [63:0] alu;
        logic [63:0] mem;
        logic [63:0] crd;
        logic [63:0] cwd;
        logic        ext_p;
        logic        tim_p;
        logic        take;
        logic        writes;
        r  = next_rand();
        r2 = next_rand();
        case (r[2:0])
            3'd0:       op = `OP_LOAD;
            3'd1:       op = `OP_IMM;
            3'd2:       op = `OP_REG;
            3'd3, 3'd4: op = `OP_SYSTEM;
            3'd5:       op = `OP_JAL;
            3'd6:       op = `OP_JALR;
            default:    op = 7'b0100011;
        endcase
        if (mode == 4) op = `OP_SYSTEM;
        rd = (r[15:13] == 3'd0) ? 5'd0 : r[12:8];
        case (r[18:16])
            3'd0:    csr = `CSR_MSTATUS;
            3'd1:    csr = `CSR_MIE;
            3'd2:    csr = `CSR_MTVEC;
            3'd3:    csr = `CSR_MSCRATCH;
            3'd4:    csr = `CSR_MEPC;
            3'd5:    csr = `CSR_MCAUSE;
            default: csr = (mode == 4) ? `CSR_MSCRATCH : 12'hBC0;
        endcase
        // Irq modes keep re-enabling MIE while the disabled mode never touches mie
        if (mode == 2 || mode == 3)
            csr = r[19] ? `CSR_MSTATUS : ((mode == 2) ? `CSR_MIE : `CSR_MSCRATCH);
        exc = 8'h00;
        if (mode == 1) exc = r2[8] ? (8'h01 << r2[11:9]) : r2[7:0];
        if ((mode == 1 && exc == 8'h00) || mode == 5) exc = 8'h10;
        priv = (r2[13:12] == 2'd2) ? 2'd3 : r2[13:12];
        pc  = rand64();
        npc = rand64();
        alu = rand64();
        mem = rand64();
        crd = rand64();
        cwd = rand64();

        // Decision on state from before the sampling edge
        ext_p = m_sync_e[1] && m_mie && m_meie;
        tim_p = m_sync_t[1] && m_mie && m_mtie;
        take  = ext_p || tim_p || (exc != 8'h00);
        writes = 1'b1;
        case (op)
            `OP_LOAD:           nxt_exp.data = mem;
            `OP_IMM, `OP_REG:   nxt_exp.data = alu;
            `OP_SYSTEM:         nxt_exp.data = crd;
            `OP_JAL, `OP_JALR:  nxt_exp.data = npc;
            default: begin
                nxt_exp.data = alu;
                writes       = 1'b0;
            end
        endcase
        nxt_exp.rd     = rd;
        nxt_exp.we     = writes && !take && (rd != 5'd0);
        nxt_exp.trap   = take;
        nxt_exp.cause  = rank_cause(exc, priv, ext_p, tim_p);
        nxt_exp.redir  = take || op == `OP_JAL || op == `OP_JALR;
        nxt_exp.target = take ? {m_mtvec[63:2], 2'b00} : alu;

        // Trap entry kills the CSR write
        if (take) begin
            m_mepc   = pc;
            m_mcause = nxt_exp.cause;
            m_mpie   = m_mie;
            m_mie    = 1'b0;
        end else if (op == `OP_SYSTEM) begin
            model_write(csr, cwd);
        end

        wb_valid      <= 1'b1;
        wb_ir         <= {csr, r[24:20], r[27:25], rd, op};
        wb_pc         <= pc;
        wb_npc        <= npc;
        wb_alu_result <= alu;
        wb_mem_result <= mem;
        wb_csr_rdata  <= crd;
        wb_csr_wdata  <= cwd;
        wb_exc        <= exc;
        privilege     <= priv;
        if (mode == 2 || mode == 3) begin
            timer_irq <= r2[14];
            ext_irq   <= r2[15];
        end
    endtask

    task automatic go_idle();
        wb_valid <= 1'b0;
        nxt_exp  = '0;
    endtask

    task automatic check_outputs();
        checks++;
        if (rf_we !== cur_exp.we) report_value("rf_we", 64'(rf_we), 64'(cur_exp.we));
        if (redirect !== cur_exp.redir)
            report_value("redirect", 64'(redirect), 64'(cur_exp.redir));
        if (trap_taken !== cur_exp.trap)
            report_value("trap_taken", 64'(trap_taken), 64'(cur_exp.trap));
        if (cur_exp.we && rf_rd !== cur_exp.rd)
            report_value("rf_rd", 64'(rf_rd), 64'(cur_exp.rd));
        if (cur_exp.we && rf_data !== cur_exp.data)
            report_value("rf_data", rf_data, cur_exp.data);
        if (cur_exp.redir && redirect_target !== cur_exp.target)
            report_value("redirect_target", redirect_target, cur_exp.target);
        if (cur_exp.trap && trap_cause !== cur_exp.cause)
            report_value("trap_cause", trap_cause, cur_exp.cause);
        // Interrupts the DUT actually took
        if (trap_taken === 1'b1 && trap_cause[63] === 1'b1)
            irq_taken++;
    endtask

    // Back to back instructions each checked one cycle later
    task automatic run_stream(input int n, input int mode);
        for (int k = 0; k < n; k++) begin
            tick();
            present(mode);
            @(negedge CLK);
            check_outputs();
            cur_exp = nxt_exp;
        end
        tick();
        go_idle();
        @(negedge CLK);
        check_outputs();
        cur_exp = nxt_exp;
    endtask

    // Called at a falling edge inside the access phase
    task automatic wait_ready(output logic ok);
        int n;
        n = 0;
        while (!PREADY && n < 50) begin
            tick();
            @(negedge CLK);
            n++;
        end
        ok = PREADY;
        if (!ok) begin
            $display("APB transfer at offset %h got no PREADY within 50 cycles", PADDR);
            errors++;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [63:0] wdata,
                            output logic [63:0] rdata, output logic err);
        logic ok;
        tick();
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= wr;
        PADDR   <= addr;
        PWDATA  <= wdata;
        tick();
        PENABLE <= 1'b1;
        @(negedge CLK);
        wait_ready(ok);
        rdata = PRDATA;
        err   = PSLVERR;
        if (ok && wr) model_write(offset_to_csr(addr), wdata);
        tick();
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic check_all_csrs();
        logic [63:0] got;
        logic        err;
        logic [7:0]  off;
        for (int k = 0; k < 6; k++) begin
            off = 8'(k * 4);
            apb_xfer(1'b0, off, 64'd0, got, err);
            checks++;
            if (err) begin
                $display("Unexpected PSLVERR reading offset %h", off);
                errors++;
            end
            if (got !== model_read(offset_to_csr(off)))
                report_value("PRDATA", got, model_read(offset_to_csr(off)));
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s: %0d errors", num, name, errors - test_errs);
        test_errs = errors;
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [63:0] rd_val;
        logic [63:0] wdata;
        logic        err;
        logic        ok;
        seed = 32'h092cdd78;
        errors = 0;
        checks = 0;
        test_errs = 0;
        irq_taken = 0;
        {m_mie, m_mpie, m_mtie, m_meie} = 4'b0000;
        m_mtvec = '0;
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_sync_t = '0;
        m_sync_e = '0;
        cur_exp = '0;
        nxt_exp = '0;
        rst = 1'b1;
        wb_valid = 1'b0;
        wb_pc = '0;
        wb_npc = '0;
        wb_ir = '0;
        wb_alu_result = '0;
        wb_mem_result = '0;
        wb_csr_rdata = '0;
        wb_csr_wdata = '0;
        wb_exc = '0;
        timer_irq = 1'b0;
        ext_irq = 1'b0;
        privilege = 2'd3;
        PSEL = 1'b0;
        PENABLE = 1'b0;
        PWRITE = 1'b0;
        PADDR = '0;
        PWDATA = '0;
        repeat (8) tick();
        rst <= 1'b0;

        // Reset values
        @(negedge CLK);
        checks++;
        if (rf_we !== 1'b0 || redirect !== 1'b0 || trap_taken !== 1'b0 || PREADY !== 1'b0) begin
            $display("Control outputs not low after reset");
            errors++;
        end
        check_all_csrs();
        end_test(1, "reset state");

        // Write every CSR, read back, then an unmapped offset
        for (int i = 0; i < 6; i++)
            apb_xfer(1'b1, 8'(i * 4), rand64(), rd_val, err);
        check_all_csrs();
        apb_xfer(1'b1, 8'h18, rand64(), rd_val, err);
        checks++;
        if (!err) begin
            $display("No PSLVERR on write to unmapped offset 18");
            errors++;
        end
        apb_xfer(1'b0, 8'hFC, 64'd0, rd_val, err);
        checks++;
        if (!err) begin
            $display("No PSLVERR on read from unmapped offset fc");
            errors++;
        end
        if (rd_val !== 64'd0) report_value("PRDATA", rd_val, 64'd0);
        check_all_csrs();
        end_test(2, "APB access");

        run_stream(500, 0);
        end_test(3, "random instructions");

        for (int i = 0; i < 30; i++) begin
            run_stream(1, 4);
            check_all_csrs();
        end
        end_test(4, "CSR instructions");

        // Random MIE before each burst so MPIE stacking shows
        for (int i = 0; i < 40; i++) begin
            apb_xfer(1'b1, `APB_MSTATUS, rand64(), rd_val, err);
            run_stream(5, 1);
            check_all_csrs();
        end
        end_test(5, "exceptions");

        // Sources masked in mie first
        apb_xfer(1'b1, `APB_MIE, 64'd0, rd_val, err);
        apb_xfer(1'b1, `APB_MSTATUS, 64'h8, rd_val, err);
        irq_taken = 0;
        run_stream(100, 3);
        checks++;
        if (irq_taken != 0) begin
            $display("Interrupt taken while its enable was clear");
            errors++;
        end
        apb_xfer(1'b1, `APB_MIE, 64'h880, rd_val, err);
        apb_xfer(1'b1, `APB_MSTATUS, 64'h8, rd_val, err);
        run_stream(200, 2);
        checks++;
        if (irq_taken == 0) begin
            $display("No interrupt was taken with interrupts enabled");
            errors++;
        end

        // APB write to mscratch overlapping a trapping instruction
        wdata = rand64();
        tick();
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= 1'b1;
        PADDR   <= `APB_MSCRATCH;
        PWDATA  <= wdata;
        tick();
        PENABLE <= 1'b1;
        present(5);
        @(negedge CLK);
        checks++;
        if (PREADY !== 1'b0) begin
            $display("PREADY was high while a trap retired");
            errors++;
        end
        check_outputs();
        cur_exp = nxt_exp;
        tick();
        go_idle();
        @(negedge CLK);
        check_outputs();
        cur_exp = nxt_exp;
        wait_ready(ok);
        if (ok) model_write(`CSR_MSCRATCH, wdata);
        tick();
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
        check_all_csrs();
        end_test(6, "interrupts and APB wait");

        $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- src/wb_top.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wb_top (
    input  logic                CLK,
    input  logic                rst,
    input  logic                wb_valid,
    input  logic [`XLEN-1:0]    wb_pc,
    input  logic [`XLEN-1:0]    wb_npc,
    input  logic [31:0]         wb_ir,
    input  logic [`XLEN-1:0]    wb_alu_result,
    input  logic [`XLEN-1:0]    wb_mem_result,
    input  logic [`XLEN-1:0]    wb_csr_rdata,
    input  logic [`XLEN-1:0]    wb_csr_wdata,
    input  wb_pkg::exc_flags_t  wb_exc,
    input  logic                timer_irq,
    input  logic                ext_irq,
    input  logic [1:0]          privilege,
    input  logic                PSEL,
    input  logic                PENABLE,
    input  logic                PWRITE,
    input  logic [7:0]          PADDR,
    input  logic [`XLEN-1:0]    PWDATA,
    output logic                rf_we,
    output logic [4:0]          rf_rd,
    output logic [`XLEN-1:0]    rf_data,
    output logic                redirect,
    output logic [`XLEN-1:0]    redirect_target,
    output logic                trap_taken,
    output logic [`XLEN-1:0]    trap_cause,
    output logic [`XLEN-1:0]    PRDATA,
    output logic                PREADY,
    output logic                PSLVERR
);

    // Trap request and CSR state shared by the three blocks
    trap_if tif ();

    trap_unit u_trap (
        .CLK       (CLK),
        .rst       (rst),
        .wb_exc    (wb_exc),
        .timer_irq (timer_irq),
        .ext_irq   (ext_irq),
        .privilege (privilege),
        .trap      (tif.unit)
    );

    // APB slave lives here
    csr_bank u_csr (
        .CLK     (CLK),
        .rst     (rst),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR),
        .trap    (tif.csr)
    );

    writeback_stage u_wb (
        .CLK             (CLK),
        .rst             (rst),
        .wb_valid        (wb_valid),
        .wb_pc           (wb_pc),
        .wb_npc          (wb_npc),
        .wb_ir           (wb_ir),
        .wb_alu_result   (wb_alu_result),
        .wb_mem_result   (wb_mem_result),
        .wb_csr_rdata    (wb_csr_rdata),
        .wb_csr_wdata    (wb_csr_wdata),
        .rf_we           (rf_we),
        .rf_rd           (rf_rd),
        .rf_data         (rf_data),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .trap_taken      (trap_taken),
        .trap_cause      (trap_cause),
        .trap            (tif.stage)
    );

endmodule

//--- src/writeback_stage.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module writeback_stage (
    input  logic              CLK,
    input  logic              rst,
    input  logic              wb_valid,
    input  logic [`XLEN-1:0]  wb_pc,
    input  logic [`XLEN-1:0]  wb_npc,
    input  wb_pkg::instr_u    wb_ir,
    input  logic [`XLEN-1:0]  wb_alu_result,
    input  logic [`XLEN-1:0]  wb_mem_result,
    input  logic [`XLEN-1:0]  wb_csr_rdata,
    input  logic [`XLEN-1:0]  wb_csr_wdata,
    output logic              rf_we,
    output logic [4:0]        rf_rd,
    output logic [`XLEN-1:0]  rf_data,
    output logic              redirect,
    output logic [`XLEN-1:0]  redirect_target,
    output logic              trap_taken,
    output logic [`XLEN-1:0]  trap_cause,
    trap_if.stage             trap
);

    import wb_pkg::*;

    wb_kind_e         kind;
    logic [`XLEN-1:0] result;
    logic             writes_rd;

    // Opcode to result source
    always_comb begin
        case (wb_ir.r.opcode)
            `OP_LOAD:            kind = KIND_LOAD;
            `OP_IMM, `OP_REG:    kind = KIND_ALU;
            `OP_SYSTEM:          kind = KIND_CSR;
            `OP_JAL, `OP_JALR:   kind = KIND_LINK;
            default:             kind = KIND_NONE;
        endcase
    end

    // CSR ops return the old value, jumps return the link address
    always_comb begin
        case (kind)
            KIND_LOAD: result = wb_mem_result;
            KIND_CSR:  result = wb_csr_rdata;
            KIND_LINK: result = wb_npc;
            default:   result = wb_alu_result;
        endcase
    end

    // A trap kills the register write, x0 never written
    assign writes_rd = wb_valid && !trap.take && (kind != KIND_NONE)
                       && (wb_ir.r.rd != 5'd0);

    //////////////////////////////
    // Toward the CSR bank
    //////////////////////////////
    assign trap.retire    = wb_valid;
    assign trap.epc       = wb_pc;
    assign trap.csr_we    = wb_valid && !trap.take && (kind == KIND_CSR);
    assign trap.csr_addr  = wb_ir.i.imm;
    assign trap.csr_wdata = wb_csr_wdata;

    // Control outputs, low when nothing retires
    always_ff @(posedge CLK) begin
        if (rst) begin
            rf_we      <= 1'b0;
            redirect   <= 1'b0;
            trap_taken <= 1'b0;
        end else begin
            rf_we      <= writes_rd;
            redirect   <= wb_valid && (trap.take || kind == KIND_LINK);
            trap_taken <= trap.take;
        end
    end

    // Payload, held while idle
    always_ff @(posedge CLK) begin
        if (wb_valid) begin
            rf_rd           <= wb_ir.r.rd;
            rf_data         <= result;
            redirect_target <= trap.take ? trap.mtvec_base : wb_alu_result;
            trap_cause      <= trap.cause;
        end
    end

endmodule

//--- src/csr_bank.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module csr_bank (
    input  logic              CLK,
    input  logic              rst,
    input  logic              PSEL,
    input  logic              PENABLE,
    input  logic              PWRITE,
    input  logic [7:0]        PADDR,
    input  logic [`XLEN-1:0]  PWDATA,
    output logic [`XLEN-1:0]  PRDATA,
    output logic              PREADY,
    output logic              PSLVERR,
    trap_if.csr               trap
);

    // Stored state, only implemented bits of mstatus and mie
    logic             mst_mie;
    logic             mst_mpie;
    logic             mie_mtie;
    logic             mie_meie;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mscratch;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;

    // One-hot selects, order mstatus mie mtvec mscratch mepc mcause
    logic [5:0]       pipe_sel;
    logic [5:0]       apb_sel;
    logic [5:0]       wr_sel;
    logic [`XLEN-1:0] wr_data;
    logic [`XLEN-1:0] mstatus_view;
    logic [`XLEN-1:0] mie_view;
    logic             pipe_busy;

    //////////////////////////////
    // APB handshake
    //////////////////////////////

    // Pipeline updates win, master waits
    assign pipe_busy = trap.retire && (trap.take || trap.csr_we);
    assign PREADY    = PSEL && PENABLE && !pipe_busy;
    assign PSLVERR   = PREADY && !(|apb_sel);

    always_comb begin
        apb_sel[0] = (PADDR == `APB_MSTATUS);
        apb_sel[1] = (PADDR == `APB_MIE);
        apb_sel[2] = (PADDR == `APB_MTVEC);
        apb_sel[3] = (PADDR == `APB_MSCRATCH);
        apb_sel[4] = (PADDR == `APB_MEPC);
        apb_sel[5] = (PADDR == `APB_MCAUSE);
    end

    always_comb begin
        pipe_sel[0] = (trap.csr_addr == `CSR_MSTATUS);
        pipe_sel[1] = (trap.csr_addr == `CSR_MIE);
        pipe_sel[2] = (trap.csr_addr == `CSR_MTVEC);
        pipe_sel[3] = (trap.csr_addr == `CSR_MSCRATCH);
        pipe_sel[4] = (trap.csr_addr == `CSR_MEPC);
        pipe_sel[5] = (trap.csr_addr == `CSR_MCAUSE);
    end

    // Full-width views of the sparse registers
    always_comb begin
        mstatus_view                = '0;
        mstatus_view[`MSTATUS_MIE]  = mst_mie;
        mstatus_view[`MSTATUS_MPIE] = mst_mpie;
        mie_view                    = '0;
        mie_view[`MIE_MTIE]         = mie_mtie;
        mie_view[`MIE_MEIE]         = mie_meie;
    end

    // Read data only in the completing cycle, zero when unmapped
    always_comb begin
        PRDATA = '0;
        if (PREADY && !PWRITE) begin
            if (apb_sel[0]) PRDATA = mstatus_view;
            if (apb_sel[1]) PRDATA = mie_view;
            if (apb_sel[2]) PRDATA = mtvec;
            if (apb_sel[3]) PRDATA = mscratch;
            if (apb_sel[4]) PRDATA = mepc;
            if (apb_sel[5]) PRDATA = mcause;
        end
    end

    //////////////////////////////
    // Write port arbitration
    //////////////////////////////

    // Pipeline write first, APB only on a completing write
    always_comb begin
        wr_sel  = '0;
        wr_data = PWDATA;
        if (trap.csr_we) begin
            wr_sel  = pipe_sel;
            wr_data = trap.csr_wdata;
        end else if (PREADY && PWRITE) begin
            wr_sel = apb_sel;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            mst_mie  <= 1'b0;
            mst_mpie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_meie <= 1'b0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (trap.take) begin
            // Trap entry, stack MIE into MPIE
            mepc     <= trap.epc;
            mcause   <= trap.cause;
            mst_mpie <= mst_mie;
            mst_mie  <= 1'b0;
        end else begin
            if (wr_sel[0]) begin
                mst_mie  <= wr_data[`MSTATUS_MIE];
                mst_mpie <= wr_data[`MSTATUS_MPIE];
            end
            if (wr_sel[1]) begin
                mie_mtie <= wr_data[`MIE_MTIE];
                mie_meie <= wr_data[`MIE_MEIE];
            end
            if (wr_sel[2]) mtvec    <= wr_data;
            if (wr_sel[3]) mscratch <= wr_data;
            if (wr_sel[4]) mepc     <= wr_data;
            if (wr_sel[5]) mcause   <= wr_data;
        end
    end

    // Enables and direct-mode base back to the trap path
    assign trap.mie_global = mst_mie;
    assign trap.mtie       = mie_mtie;
    assign trap.meie       = mie_meie;
    assign trap.mtvec_base = {mtvec[`XLEN-1:2], 2'b00};

endmodule

//--- src/trap_unit.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module trap_unit (
    input  logic                CLK,
    input  logic                rst,
    input  wb_pkg::exc_flags_t  wb_exc,
    input  logic                timer_irq,
    input  logic                ext_irq,
    input  logic [1:0]          privilege,
    trap_if.unit                trap
);

    logic [1:0] timer_sync;
    logic [1:0] ext_sync;
    logic       timer_pend;
    logic       ext_pend;
    logic       any_exc;
    logic       is_irq;
    logic [5:0] code;
    logic [5:0] ecall_code;

    //////////////////////////////
    // Interrupt synchronizers
    //////////////////////////////

    // Two flops each, so a request shows up two cycles late
    always_ff @(posedge CLK) begin
        if (rst) begin
            timer_sync <= '0;
            ext_sync   <= '0;
        end else begin
            timer_sync <= {timer_sync[0], timer_irq};
            ext_sync   <= {ext_sync[0], ext_irq};
        end
    end

    // Gated by global and per-source enables
    assign ext_pend   = ext_sync[1] && trap.mie_global && trap.meie;
    assign timer_pend = timer_sync[1] && trap.mie_global && trap.mtie;
    assign any_exc    = |wb_exc;

    //////////////////////////////
    // Cause ranking
    //////////////////////////////

    // Ecall code follows current privilege
    always_comb begin
        case (privilege)
            2'd0:    ecall_code = `CAUSE_ECALL_U;
            2'd1:    ecall_code = `CAUSE_ECALL_S;
            default: ecall_code = `CAUSE_ECALL_M;
        endcase
    end

    // Interrupts first, external over timer
    always_comb begin
        is_irq = 1'b0;
        code   = '0;
        if (ext_pend) begin
            is_irq = 1'b1;
            code   = `CAUSE_MEI;
        end else if (timer_pend) begin
            is_irq = 1'b1;
            code   = `CAUSE_MTI;
        end else if (wb_exc.iaf)   code = `CAUSE_IAF;
        else if (wb_exc.iam)       code = `CAUSE_IAM;
        else if (wb_exc.ii)        code = `CAUSE_II;
        else if (wb_exc.ecall)     code = ecall_code;
        else if (wb_exc.lam)       code = `CAUSE_LAM;
        else if (wb_exc.laf)       code = `CAUSE_LAF;
        else if (wb_exc.sam)       code = `CAUSE_SAM;
        else if (wb_exc.saf)       code = `CAUSE_SAF;
    end

    // Only a retiring instruction can trap
    assign trap.take  = trap.retire && (ext_pend || timer_pend || any_exc);
    assign trap.cause = trap.take ? {is_irq, {(`XLEN-7){1'b0}}, code} : '0;

endmodule

//--- src/trap_if.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

interface trap_if;

    // From the trap unit
    logic              take;
    logic [`XLEN-1:0]  cause;

    // From the CSR bank
    logic              mie_global;
    logic              mtie;
    logic              meie;
    logic [`XLEN-1:0]  mtvec_base;

    // From the writeback stage
    logic              retire;
    logic [`XLEN-1:0]  epc;
    logic              csr_we;
    logic [11:0]       csr_addr;
    logic [`XLEN-1:0]  csr_wdata;

    modport unit  (input retire, mie_global, mtie, meie, output take, cause);
    modport stage (input take, cause, mtvec_base,
                   output retire, epc, csr_we, csr_addr, csr_wdata);
    modport csr   (input take, cause, retire, epc, csr_we, csr_addr, csr_wdata,
                   output mie_global, mtie, meie, mtvec_base);

endinterface

//--- src/wb_pkg.sv
package wb_pkg;

    // Instruction word, two decodings
    // CSR instructions carry the CSR address in the I-type immediate
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

    // Source of the register file write
    typedef enum logic [2:0] {
        KIND_NONE,
        KIND_LOAD,
        KIND_ALU,
        KIND_CSR,
        KIND_LINK
    } wb_kind_e;

    // Exception flags gathered along the pipe
    typedef struct packed {
        logic iam;
        logic iaf;
        logic ii;
        logic ecall;
        logic lam;
        logic laf;
        logic sam;
        logic saf;
    } exc_flags_t;

endpackage

//--- src/wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// Data width
`define XLEN 64

// Major opcodes
`define OP_LOAD   7'b0000011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011
`define OP_SYSTEM 7'b1110011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111

// Machine trap CSR addresses
`define CSR_MSTATUS  12'h300
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342

// Field positions inside mstatus and mie
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7
`define MIE_MTIE     7
`define MIE_MEIE     11

// Exception cause codes
`define CAUSE_IAM     6'd0
`define CAUSE_IAF     6'd1
`define CAUSE_II      6'd2
`define CAUSE_LAM     6'd4
`define CAUSE_LAF     6'd5
`define CAUSE_SAM     6'd6
`define CAUSE_SAF     6'd7
`define CAUSE_ECALL_U 6'd8
`define CAUSE_ECALL_S 6'd9
`define CAUSE_ECALL_M 6'd11

// Interrupt cause codes, bit 63 set separately
`define CAUSE_MTI 6'd7
`define CAUSE_MEI 6'd11

// APB word offsets of the CSRs
`define APB_MSTATUS  8'h00
`define APB_MIE      8'h04
`define APB_MTVEC    8'h08
`define APB_MSCRATCH 8'h0C
`define APB_MEPC     8'h10
`define APB_MCAUSE   8'h14

`endif
